// ==== Makefile ====
TOP := cpu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== logic/cpu_control_unit.sv ====
//--------------------------------------------------------------------------
// opcode decoder, one set of datapath control levels per instruction
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_control_unit (
    input  logic                              rst_n,
    input  logic [cpu_isa_pkg::op_w-1:0]      opcode,
    output logic                              write_en,
    output logic                              neg_sel,
    output logic                              imm_sel,
    output logic                              shift_rev,
    output logic                              jump,
    output logic [cpu_ctrl_pkg::alu_op_w-1:0] alu_op,
    output logic [cpu_ctrl_pkg::br_w-1:0]     branch
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic write_dec;

    always_comb begin
        // defaults form a no-op
        write_dec = 1'b0;
        neg_sel   = 1'b0;
        imm_sel   = 1'b0;
        shift_rev = 1'b0;
        jump      = 1'b0;
        alu_op    = alu_fwd;
        branch    = br_none;
        case (opcode)
            op_loadi: begin
                write_dec = 1'b1;
                imm_sel   = 1'b1;
            end
            // forward register b
            op_mov: write_dec = 1'b1;
            op_add: begin
                write_dec = 1'b1;
                alu_op    = alu_add;
            end
            // a plus two's complement of b
            op_sub: begin
                write_dec = 1'b1;
                neg_sel   = 1'b1;
                alu_op    = alu_add;
            end
            op_and: begin
                write_dec = 1'b1;
                alu_op    = alu_and;
            end
            op_or: begin
                write_dec = 1'b1;
                alu_op    = alu_or;
            end
            op_j: jump = 1'b1;
            // compares subtract, no write back
            op_beq: begin
                neg_sel = 1'b1;
                alu_op  = alu_add;
                branch  = br_eq;
            end
            op_bne: begin
                neg_sel = 1'b1;
                alu_op  = alu_add;
                branch  = br_ne;
            end
            // left shift is srl between two reversals
            op_sll: begin
                write_dec = 1'b1;
                imm_sel   = 1'b1;
                shift_rev = 1'b1;
                alu_op    = alu_srl;
            end
            op_srl: begin
                write_dec = 1'b1;
                imm_sel   = 1'b1;
                alu_op    = alu_srl;
            end
            default: ;
        endcase
    end

    // no register writes while reset is held
    assign write_en = write_dec & rst_n;

endmodule

// ==== logic/cpu_core.sv ====
//--------------------------------------------------------------------------
// single-cycle 8-bit core top, fed one instruction per clock at address pc
// register write-back is mirrored on the wb trace port
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [cpu_isa_pkg::inst_w-1:0]      instruction,
    output logic [cpu_isa_pkg::inst_w-1:0]      pc,
    output logic                                wb_en,
    output logic [cpu_isa_pkg::reg_addr_w-1:0]  wb_addr,
    output logic [cpu_isa_pkg::data_w-1:0]      wb_data
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    // instruction fields
    logic [op_w-1:0]       opcode;
    logic [7:0]            offset;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [data_w-1:0]     imm;

    // control levels
    logic                  write_en;
    logic                  neg_sel;
    logic                  imm_sel;
    logic                  shift_rev;
    logic                  jump;
    logic [alu_op_w-1:0]   alu_op;
    logic [br_w-1:0]       branch;

    // datapath
    logic [data_w-1:0]     rd_data1;
    logic [data_w-1:0]     rd_data2;
    logic [data_w-1:0]     result;
    logic                  zero;

    assign opcode = instruction[op_hi:op_lo];
    assign offset = instruction[off_hi:off_lo];
    assign rd     = instruction[rd_hi:rd_lo];
    assign rs1    = instruction[rs1_hi:rs1_lo];
    assign rs2    = instruction[rs2_hi:rs2_lo];
    assign imm    = instruction[imm_hi:imm_lo];

    cpu_pc pc_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .offset (offset),
        .jump   (jump),
        .branch (branch),
        .zero   (zero),
        .pc     (pc)
    );

    cpu_control_unit control_inst (
        .rst_n     (rst_n),
        .opcode    (opcode),
        .write_en  (write_en),
        .neg_sel   (neg_sel),
        .imm_sel   (imm_sel),
        .shift_rev (shift_rev),
        .jump      (jump),
        .alu_op    (alu_op),
        .branch    (branch)
    );

    // write port takes the alu result straight back
    cpu_reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (rs1),
        .rd_addr2 (rs2),
        .wr_addr  (rd),
        .wr_data  (result),
        .write_en (write_en),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    cpu_exec_unit exec_inst (
        .op_a      (rd_data1),
        .op_b      (rd_data2),
        .imm       (imm),
        .neg_sel   (neg_sel),
        .imm_sel   (imm_sel),
        .shift_rev (shift_rev),
        .alu_op    (alu_op),
        .result    (result),
        .zero      (zero)
    );

    // trace of the write about to happen at the next edge
    assign wb_en   = write_en;
    assign wb_addr = rd;
    assign wb_data = result;

endmodule

// ==== logic/cpu_ctrl_pkg.sv ====
//--------------------------------------------------------------------------
// internal control encodings passed from the decoder to the datapath
//--------------------------------------------------------------------------
package cpu_ctrl_pkg;

    // alu operation select
    localparam int alu_op_w = 3;

    // pass operand b straight through, used by loadi and mov
    localparam logic [alu_op_w-1:0] alu_fwd = 3'd0;
    // sum, sub and compares come in with b already negated
    localparam logic [alu_op_w-1:0] alu_add = 3'd1;
    localparam logic [alu_op_w-1:0] alu_and = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
    // logical right shift by low 3 bits of b
    localparam logic [alu_op_w-1:0] alu_srl = 3'd4;

    // branch condition select
    localparam int br_w = 2;

    localparam logic [br_w-1:0] br_none = 2'd0;
    // taken when the compare result is zero
    localparam logic [br_w-1:0] br_eq   = 2'd1;
    // taken when it is not
    localparam logic [br_w-1:0] br_ne   = 2'd2;

endpackage

// ==== logic/cpu_exec_unit.sv ====
//--------------------------------------------------------------------------
// operand muxing, optional bit reversal around the alu, and the zero flag
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_exec_unit (
    input  logic [cpu_isa_pkg::data_w-1:0]    op_a,
    input  logic [cpu_isa_pkg::data_w-1:0]    op_b,
    input  logic [cpu_isa_pkg::data_w-1:0]    imm,
    input  logic                              neg_sel,
    input  logic                              imm_sel,
    input  logic                              shift_rev,
    input  logic [cpu_ctrl_pkg::alu_op_w-1:0] alu_op,
    output logic [cpu_isa_pkg::data_w-1:0]    result,
    output logic                              zero
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [data_w-1:0] b_neg;
    logic [data_w-1:0] b_sel;
    logic [data_w-1:0] a_in;
    logic [data_w-1:0] alu_out;

    // mirror bit order, msb swaps with lsb
    function automatic logic [data_w-1:0] bit_rev(input logic [data_w-1:0] val);
        logic [data_w-1:0] rev;
        for (int i = 0; i < data_w; i++) begin
            rev[i] = val[data_w-1-i];
        end
        return rev;
    endfunction

    // two's complement of register b
    assign b_neg = ~op_b + data_w'(1);

    // register, negated register, or immediate
    always_comb begin
        b_sel = neg_sel ? b_neg : op_b;
        if (imm_sel) begin
            b_sel = imm;
        end
    end

    // reversed input turns srl into sll
    assign a_in = shift_rev ? bit_rev(op_a) : op_a;

    always_comb begin
        case (alu_op)
            alu_fwd: alu_out = b_sel;
            alu_add: alu_out = a_in + b_sel;
            alu_and: alu_out = a_in & b_sel;
            alu_or:  alu_out = a_in | b_sel;
            // only the low 3 bits count as amount
            alu_srl: alu_out = a_in >> b_sel[2:0];
            default: alu_out = '0;
        endcase
    end

    // undo the reversal on the way out
    assign result = shift_rev ? bit_rev(alu_out) : alu_out;

    // beq and bne test this after a - b
    assign zero = (result == '0);

endmodule

// ==== logic/cpu_isa_pkg.sv ====
//--------------------------------------------------------------------------
// instruction set of the 8-bit core: widths, opcodes and field positions
// imported by the core, its decoder and the testbench program builder
//--------------------------------------------------------------------------
package cpu_isa_pkg;

    // datapath and instruction widths
    localparam int data_w     = 8;
    localparam int inst_w     = 32;
    localparam int reg_addr_w = 3;
    localparam int op_w       = 8;

    // opcode values, top byte of the instruction
    localparam logic [op_w-1:0] op_loadi = 8'd0;
    localparam logic [op_w-1:0] op_mov   = 8'd1;
    localparam logic [op_w-1:0] op_add   = 8'd2;
    localparam logic [op_w-1:0] op_sub   = 8'd3;
    localparam logic [op_w-1:0] op_and   = 8'd4;
    localparam logic [op_w-1:0] op_or    = 8'd5;
    localparam logic [op_w-1:0] op_j     = 8'd6;
    localparam logic [op_w-1:0] op_beq   = 8'd7;
    localparam logic [op_w-1:0] op_bne   = 8'd8;
    localparam logic [op_w-1:0] op_sll   = 8'd9;
    localparam logic [op_w-1:0] op_srl   = 8'd10;

    // field positions inside the 32-bit word
    localparam int op_hi   = 31;
    localparam int op_lo   = 24;
    // branch offset overlaps the destination field
    localparam int off_hi  = 23;
    localparam int off_lo  = 16;
    localparam int rd_hi   = 18;
    localparam int rd_lo   = 16;
    localparam int rs1_hi  = 10;
    localparam int rs1_lo  = 8;
    localparam int rs2_hi  = 2;
    localparam int rs2_lo  = 0;
    localparam int imm_hi  = 7;
    localparam int imm_lo  = 0;

endpackage

// ==== logic/cpu_pc.sv ====
//--------------------------------------------------------------------------
// program counter with pc+4, word offset branch target and next-pc select
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_pc (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [7:0]                       offset,
    input  logic                             jump,
    input  logic [cpu_ctrl_pkg::br_w-1:0]    branch,
    input  logic                             zero,
    output logic [cpu_isa_pkg::inst_w-1:0]   pc
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [inst_w-1:0] pc_plus4;
    logic [inst_w-1:0] offset_ext;
    logic [inst_w-1:0] target;
    logic [inst_w-1:0] pc_next;
    logic              take;

    // sequential address
    assign pc_plus4 = pc + inst_w'(4);

    // sign extend and scale to bytes
    assign offset_ext = {{(inst_w - 10){offset[7]}}, offset, 2'b00};

    // offset counts from the next instruction
    assign target = pc_plus4 + offset_ext;

    // jump always goes, branches follow the compare
    always_comb begin
        take = jump;
        if (branch == br_eq && zero) begin
            take = 1'b1;
        end
        if (branch == br_ne && !zero) begin
            take = 1'b1;
        end
    end

    assign pc_next = take ? target : pc_plus4;

    // one edge per instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// ==== logic/cpu_reg_file.sv ====
//--------------------------------------------------------------------------
// eight 8-bit registers, two combinational reads and one clocked write
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_reg_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr1,
    input  logic [cpu_isa_pkg::reg_addr_w-1:0]  rd_addr2,
    input  logic [cpu_isa_pkg::reg_addr_w-1:0]  wr_addr,
    input  logic [cpu_isa_pkg::data_w-1:0]      wr_data,
    input  logic                                write_en,
    output logic [cpu_isa_pkg::data_w-1:0]      rd_data1,
    output logic [cpu_isa_pkg::data_w-1:0]      rd_data2
);

    import cpu_isa_pkg::*;

    localparam int num_regs = 1 << reg_addr_w;

    logic [data_w-1:0] regs [num_regs];

    // reads see the old value until the edge
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all registers start from zero
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== project.f ====
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/cpu_pc.sv
logic/cpu_control_unit.sv
logic/cpu_reg_file.sv
logic/cpu_exec_unit.sv
logic/cpu_core.sv
verif/cpu_tb_clock.sv
verif/cpu_tb.sv

// ==== verif/cpu_tb.sv ====
//--------------------------------------------------------------------------
// core testbench, plays instruction memory from a program table and checks
// the write-back trace before each edge and the pc after it
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_tb;

    import cpu_isa_pkg::*;

    localparam int num_rows      = 26;
    // rows 15 is skipped, 17 and 18 run after the backward jump
    localparam int num_exec      = 25;
    localparam int timeout_limit = 2 * num_exec + 16 + 20;
    localparam logic [inst_w-1:0] end_pc    = 32'd104;
    // unknown opcode, core only steps the pc
    localparam logic [inst_w-1:0] idle_word = 32'hff00_0000;
    localparam logic [op_w-1:0]   op_bad    = 8'hff;

    logic                  clk;
    logic                  rst_n;
    logic [inst_w-1:0]     instruction;
    logic [inst_w-1:0]     pc;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_addr;
    logic [data_w-1:0]     wb_data;

    // program table, one row per word address
    logic [inst_w-1:0]     prog_word [num_rows];
    logic                  exp_en    [num_rows];
    logic [reg_addr_w-1:0] exp_addr  [num_rows];
    logic [data_w-1:0]     exp_data  [num_rows];
    logic [inst_w-1:0]     exp_next  [num_rows];

    integer                seed;
    logic [data_w-1:0]     imm_a;
    logic [data_w-1:0]     imm_b;
    int                    errors;
    int                    checks;
    int                    cycles;
    int                    idx;
    logic [inst_w-1:0]     cur_pc;
    logic                  run_done;

    cpu_tb_clock clock_inst (
        .clk (clk)
    );

    cpu_core cpu_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    // register-register format, mov reads only rs2
    function automatic logic [inst_w-1:0] rr_word(
        input logic [op_w-1:0]       op,
        input logic [reg_addr_w-1:0] rd,
        input logic [reg_addr_w-1:0] rs1,
        input logic [reg_addr_w-1:0] rs2
    );
        logic [inst_w-1:0] w;
        w = '0;
        w[op_hi:op_lo]   = op;
        w[rd_hi:rd_lo]   = rd;
        w[rs1_hi:rs1_lo] = rs1;
        w[rs2_hi:rs2_lo] = rs2;
        return w;
    endfunction

    // immediate format for loadi and the shifts
    function automatic logic [inst_w-1:0] ri_word(
        input logic [op_w-1:0]       op,
        input logic [reg_addr_w-1:0] rd,
        input logic [reg_addr_w-1:0] rs1,
        input logic [data_w-1:0]     imm
    );
        logic [inst_w-1:0] w;
        w = '0;
        w[op_hi:op_lo]   = op;
        w[rd_hi:rd_lo]   = rd;
        w[rs1_hi:rs1_lo] = rs1;
        w[imm_hi:imm_lo] = imm;
        return w;
    endfunction

    // signed word offset in the destination byte
    function automatic logic [inst_w-1:0] branch_word(
        input logic [op_w-1:0]       op,
        input logic [7:0]            off,
        input logic [reg_addr_w-1:0] rs1,
        input logic [reg_addr_w-1:0] rs2
    );
        logic [inst_w-1:0] w;
        w = '0;
        w[op_hi:op_lo]   = op;
        w[off_hi:off_lo] = off;
        w[rs1_hi:rs1_lo] = rs1;
        w[rs2_hi:rs2_lo] = rs2;
        return w;
    endfunction

    task automatic set_row(
        input int                    row,
        input logic [inst_w-1:0]     word,
        input logic                  en,
        input logic [reg_addr_w-1:0] addr,
        input logic [data_w-1:0]     data,
        input logic [inst_w-1:0]     next
    );
        prog_word[row] = word;
        exp_en[row]    = en;
        exp_addr[row]  = addr;
        exp_data[row]  = data;
        exp_next[row]  = next;
    endtask

    // expected values worked out from the two loadi immediates
    task automatic fill_program();
        logic [data_w-1:0] sum;
        logic [data_w-1:0] diff;
        sum  = imm_a + imm_b;
        diff = imm_a - imm_b;
        // cleared register reads back zero
        set_row(0, rr_word(op_mov, 3'd3, 3'd0, 3'd0), 1'b1, 3'd3, 8'h00, 32'd4);
        set_row(1, ri_word(op_loadi, 3'd1, 3'd0, imm_a), 1'b1, 3'd1, imm_a, 32'd8);
        set_row(2, ri_word(op_loadi, 3'd2, 3'd0, imm_b), 1'b1, 3'd2, imm_b, 32'd12);
        set_row(3, rr_word(op_add, 3'd4, 3'd1, 3'd2), 1'b1, 3'd4, sum, 32'd16);
        set_row(4, rr_word(op_sub, 3'd5, 3'd1, 3'd2), 1'b1, 3'd5, diff, 32'd20);
        set_row(5, rr_word(op_and, 3'd6, 3'd1, 3'd2), 1'b1, 3'd6, imm_a & imm_b, 32'd24);
        set_row(6, rr_word(op_or, 3'd7, 3'd1, 3'd2), 1'b1, 3'd7, imm_a | imm_b, 32'd28);
        // shift amounts 0, 3 and 7 both ways
        set_row(7, ri_word(op_sll, 3'd3, 3'd1, 8'd0), 1'b1, 3'd3, imm_a, 32'd32);
        set_row(8, ri_word(op_sll, 3'd3, 3'd1, 8'd3), 1'b1, 3'd3, imm_a << 3, 32'd36);
        set_row(9, ri_word(op_sll, 3'd3, 3'd1, 8'd7), 1'b1, 3'd3, imm_a << 7, 32'd40);
        set_row(10, ri_word(op_srl, 3'd3, 3'd1, 8'd0), 1'b1, 3'd3, imm_a, 32'd44);
        set_row(11, ri_word(op_srl, 3'd3, 3'd1, 8'd3), 1'b1, 3'd3, imm_a >> 3, 32'd48);
        set_row(12, ri_word(op_srl, 3'd3, 3'd1, 8'd7), 1'b1, 3'd3, imm_a >> 7, 32'd52);
        // r1 differs from r2, so beq falls through and bne skips row 15
        set_row(13, branch_word(op_beq, 8'd5, 3'd1, 3'd2), 1'b0, 3'd0, 8'h00, 32'd56);
        set_row(14, branch_word(op_bne, 8'd1, 3'd1, 3'd2), 1'b0, 3'd0, 8'h00, 32'd64);
        set_row(15, ri_word(op_loadi, 3'd3, 3'd0, 8'hee), 1'b1, 3'd3, 8'hee, 32'd64);
        set_row(16, branch_word(op_beq, 8'd2, 3'd1, 3'd1), 1'b0, 3'd0, 8'h00, 32'd76);
        // reached only through the backward jump at row 22
        set_row(17, rr_word(op_mov, 3'd3, 3'd0, 3'd5), 1'b1, 3'd3, diff, 32'd72);
        set_row(18, branch_word(op_j, 8'd4, 3'd0, 3'd0), 1'b0, 3'd0, 8'h00, 32'd92);
        set_row(19, branch_word(op_bne, 8'd3, 3'd2, 3'd2), 1'b0, 3'd0, 8'h00, 32'd80);
        // would hit r4 if it wrote anything
        set_row(20, rr_word(op_bad, 3'd4, 3'd1, 3'd2), 1'b0, 3'd0, 8'h00, 32'd84);
        set_row(21, rr_word(op_mov, 3'd3, 3'd0, 3'd4), 1'b1, 3'd3, sum, 32'd88);
        // offset -6 words lands on row 17
        set_row(22, branch_word(op_j, 8'hfa, 3'd0, 3'd0), 1'b0, 3'd0, 8'h00, 32'd68);
        set_row(23, rr_word(op_mov, 3'd3, 3'd0, 3'd6), 1'b1, 3'd3, imm_a & imm_b, 32'd96);
        set_row(24, rr_word(op_mov, 3'd3, 3'd0, 3'd7), 1'b1, 3'd3, imm_a | imm_b, 32'd100);
        set_row(25, rr_word(op_mov, 3'd3, 3'd0, 3'd2), 1'b1, 3'd3, imm_b, end_pc);
    endtask

    task automatic check_value(
        input string       sig,
        input logic [31:0] exp_val,
        input logic [31:0] act_val
    );
        checks++;
        assert (act_val === exp_val) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, sig, exp_val, act_val);
        end
    endtask

    // address and data only matter when a write is due
    task automatic check_trace(input int row);
        check_value("wb_en", 32'(exp_en[row]), 32'(wb_en));
        if (exp_en[row]) begin
            check_value("wb_addr", 32'(exp_addr[row]), 32'(wb_addr));
            check_value("wb_data", 32'(exp_data[row]), 32'(wb_data));
        end
    endtask

    initial begin
        rst_n    <= 1'b0;
        errors   = 0;
        checks   = 0;
        run_done = 1'b0;
        cur_pc   = '0;
        seed     = 32'h26fb9914;
        imm_a    = 8'($random(seed));
        imm_b    = 8'($random(seed));
        // both end bits set so the 7-bit shifts move a one
        imm_a    = imm_a | 8'h81;
        if (imm_b == imm_a) begin
            imm_b = imm_a ^ 8'h01;
        end
        fill_program();
        // the mov at pc 0 is already up, reset has to hold its write off
        instruction <= prog_word[0];

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value("pc", 32'd0, pc);
        check_value("wb_en", 32'd0, 32'(wb_en));
        // 16th reset edge, first row runs after the release
        @(posedge clk);
        rst_n <= 1'b1;

        // feed follows the table's next pc, the DUT pc is checked against it
        while (!run_done) begin
            @(negedge clk);
            check_value("pc", cur_pc, pc);
            if (pc !== cur_pc) begin
                $display("pc left the program path at time %0t, stopping the run", $time);
                run_done = 1'b1;
            end else begin
                idx = int'(cur_pc >> 2);
                check_trace(idx);
                @(posedge clk);
                cur_pc = exp_next[idx];
                if (cur_pc == end_pc) begin
                    instruction <= idle_word;
                    run_done = 1'b1;
                end else begin
                    instruction <= prog_word[int'(cur_pc >> 2)];
                end
            end
        end

        if (cur_pc == end_pc) begin
            @(negedge clk);
            check_value("pc", end_pc, pc);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // cycle budget for reset plus the program
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout after %0d cycles, the program never reached its end", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

// ==== verif/cpu_tb_clock.sv ====
//--------------------------------------------------------------------------
// free-running 8 ns clock for the core testbench
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cpu_tb_clock (
    output logic clk
);

    // half of the 8 ns period
    localparam realtime half_period = 4ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule
